// File: hw/mem_pkg.sv
`default_nettype none

// cache line and burst geometry shared by the whole memory side
package mem_pkg;

    localparam int LINE_BITS   = 256;                    // one cache line
    localparam int BEAT_BITS   = 64;                     // one bmem beat
    localparam int BEATS       = LINE_BITS / BEAT_BITS;  // beats per line
    localparam int OFFSET_BITS = 5;                      // byte offset within a line

    typedef logic [LINE_BITS-1:0]       line_t;
    typedef logic [BEAT_BITS-1:0]       beat_t;
    typedef logic [$clog2(BEATS)-1:0]   beat_idx_t;      // wraps after the last beat

endpackage : mem_pkg

`default_nettype wire

// File: hw/arb_pkg.sv
`default_nettype none

// who owns a line transaction and where a client handshake stands
package arb_pkg;

    typedef enum logic {
        CLIENT_FETCH = 1'b0,
        CLIENT_DATA  = 1'b1
    } client_t;

    typedef enum logic [1:0] {
        PORT_IDLE    = 2'd0,    // waiting for req
        PORT_PENDING = 2'd1,    // request held for the arbiter
        PORT_ACKED   = 2'd2     // ack high, waiting for req to drop
    } port_state_t;

endpackage : arb_pkg

`default_nettype wire

// File: hw/req_port.sv
`default_nettype none

module req_port #(
    parameter int ADDR_W = 32
) (
    input  logic                clk,
    input  logic                rst,

    // client side, four-phase req/ack
    input  logic                req_i,
    input  logic [ADDR_W-1:0]   addr_i,
    input  logic                write_i,
    input  mem_pkg::line_t      wdata_i,
    output logic                ack_o,
    output mem_pkg::line_t      rdata_o,

    // arbiter side
    output logic                pending_o,
    output logic [ADDR_W-1:0]   addr_o,
    output logic                write_o,
    output mem_pkg::line_t      wdata_o,
    input  logic                done_i,
    input  mem_pkg::line_t      rdata_i
);

    arb_pkg::port_state_t state;
    arb_pkg::port_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            arb_pkg::PORT_IDLE: begin
                if (req_i) begin
                    state_next = arb_pkg::PORT_PENDING;
                end
            end
            arb_pkg::PORT_PENDING: begin
                if (done_i) begin
                    state_next = arb_pkg::PORT_ACKED;
                end
            end
            arb_pkg::PORT_ACKED: begin
                if (!req_i) begin
                    state_next = arb_pkg::PORT_IDLE;  // phase 4, ack falls next
                end
            end
            default: state_next = arb_pkg::PORT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arb_pkg::PORT_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == arb_pkg::PORT_IDLE && req_i) begin
            addr_o  <= addr_i;          // held until the next request
            write_o <= write_i;
            wdata_o <= wdata_i;
        end
        if (state == arb_pkg::PORT_PENDING && done_i) begin
            rdata_o <= rdata_i;         // stays put while ack is high
        end
    end

    assign pending_o = (state == arb_pkg::PORT_PENDING);
    assign ack_o     = (state == arb_pkg::PORT_ACKED);

endmodule : req_port

`default_nettype wire

// File: hw/fill_arbiter.sv
`default_nettype none

module fill_arbiter #(
    parameter int ADDR_W = 32
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                fetch_pending_i,
    input  logic [ADDR_W-1:0]   fetch_addr_i,
    input  logic                fetch_write_i,
    input  mem_pkg::line_t      fetch_wdata_i,

    input  logic                data_pending_i,
    input  logic [ADDR_W-1:0]   data_addr_i,
    input  logic                data_write_i,
    input  mem_pkg::line_t      data_wdata_i,

    output logic                fetch_done_o,
    output logic                data_done_o,
    output mem_pkg::line_t      rdata_o,        // shared by both ports

    // adapter side
    output logic                start_o,
    output logic [ADDR_W-1:0]   addr_o,
    output logic                write_o,
    output mem_pkg::line_t      wdata_o,
    input  logic                done_i,
    input  mem_pkg::line_t      rdata_i
);

    logic               busy;           // one transaction in flight
    logic               any_pending;
    arb_pkg::client_t   owner;          // client of the current transaction
    arb_pkg::client_t   last_grant;
    arb_pkg::client_t   pick;

    assign any_pending = fetch_pending_i | data_pending_i;

    // under contention the client served last waits
    always_comb begin
        if (fetch_pending_i && data_pending_i) begin
            pick = (last_grant == arb_pkg::CLIENT_FETCH) ? arb_pkg::CLIENT_DATA
                                                         : arb_pkg::CLIENT_FETCH;
        end else if (data_pending_i) begin
            pick = arb_pkg::CLIENT_DATA;
        end else begin
            pick = arb_pkg::CLIENT_FETCH;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            start_o      <= 1'b0;
            owner        <= arb_pkg::CLIENT_FETCH;
            last_grant   <= arb_pkg::CLIENT_DATA;    // fetch wins the first tie
            fetch_done_o <= 1'b0;
            data_done_o  <= 1'b0;
        end else begin
            start_o      <= 1'b0;
            fetch_done_o <= done_i && (owner == arb_pkg::CLIENT_FETCH);
            data_done_o  <= done_i && (owner == arb_pkg::CLIENT_DATA);
            if (!busy && any_pending) begin
                busy    <= 1'b1;
                start_o <= 1'b1;
                owner   <= pick;
            end else if (fetch_done_o || data_done_o) begin
                busy       <= 1'b0;     // port has left pending by now
                last_grant <= owner;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done_i) begin
            rdata_o <= rdata_i;         // lines up with the port done pulse
        end
    end

    // port payload is stable while pending, so a plain mux is enough
    assign addr_o  = (owner == arb_pkg::CLIENT_DATA) ? data_addr_i  : fetch_addr_i;
    assign write_o = (owner == arb_pkg::CLIENT_DATA) ? data_write_i : fetch_write_i;
    assign wdata_o = (owner == arb_pkg::CLIENT_DATA) ? data_wdata_i : fetch_wdata_i;

endmodule : fill_arbiter

`default_nettype wire

// File: hw/burst_adapter.sv
`default_nettype none

module burst_adapter #(
    parameter int ADDR_W = 32
) (
    input  logic                clk,
    input  logic                rst,

    // line request from the arbiter
    input  logic                start_i,
    input  logic [ADDR_W-1:0]   addr_i,
    input  logic                write_i,
    input  mem_pkg::line_t      wdata_i,
    output logic                done_o,
    output mem_pkg::line_t      rdata_o,

    // burst memory
    output logic [ADDR_W-1:0]   bmem_addr_o,
    output logic                bmem_read_o,
    output logic                bmem_write_o,
    output mem_pkg::beat_t      bmem_wdata_o,
    input  logic                bmem_ready_i,
    input  mem_pkg::beat_t      bmem_rdata_i,
    input  logic                bmem_rvalid_i
);

    localparam logic [1:0] ST_IDLE       = 2'd0;
    localparam logic [1:0] ST_RD_REQ     = 2'd1;   // read held until ready
    localparam logic [1:0] ST_RD_COLLECT = 2'd2;   // waiting on rvalid beats
    localparam logic [1:0] ST_WR_BEATS   = 2'd3;

    logic [1:0]             state;
    mem_pkg::beat_idx_t     beat_idx;
    logic                   last_beat;
    mem_pkg::line_t         line_q;     // write data out, read data in
    logic [ADDR_W-1:0]      addr_q;

    assign last_beat = (beat_idx == mem_pkg::beat_idx_t'(mem_pkg::BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            beat_idx <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        beat_idx <= '0;
                        state    <= write_i ? ST_WR_BEATS : ST_RD_REQ;
                    end
                end
                ST_RD_REQ: begin
                    if (bmem_ready_i) begin
                        state <= ST_RD_COLLECT;
                    end
                end
                ST_RD_COLLECT: begin
                    if (bmem_rvalid_i) begin
                        beat_idx <= beat_idx + 1'b1;
                        if (last_beat) begin
                            state  <= ST_IDLE;
                            done_o <= 1'b1;
                        end
                    end
                end
                ST_WR_BEATS: begin
                    if (bmem_ready_i) begin
                        beat_idx <= beat_idx + 1'b1;    // next beat onto wdata
                        if (last_beat) begin
                            state  <= ST_IDLE;
                            done_o <= 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start_i) begin
            addr_q <= {addr_i[ADDR_W-1:mem_pkg::OFFSET_BITS], {mem_pkg::OFFSET_BITS{1'b0}}};
            line_q <= wdata_i;
        end else if (state == ST_RD_COLLECT && bmem_rvalid_i) begin
            line_q[beat_idx*mem_pkg::BEAT_BITS +: mem_pkg::BEAT_BITS] <= bmem_rdata_i;
        end
    end

    assign bmem_addr_o  = addr_q;
    assign bmem_read_o  = (state == ST_RD_REQ);
    assign bmem_write_o = (state == ST_WR_BEATS);
    assign bmem_wdata_o = line_q[beat_idx*mem_pkg::BEAT_BITS +: mem_pkg::BEAT_BITS];
    assign rdata_o      = line_q;

endmodule : burst_adapter

`default_nettype wire

// File: hw/line_fill_top.sv
`default_nettype none

module line_fill_top #(
    parameter int ADDR_W = 32
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                fetch_req_i,
    input  logic [ADDR_W-1:0]   fetch_addr_i,
    input  logic                fetch_write_i,
    input  mem_pkg::line_t      fetch_wdata_i,
    output logic                fetch_ack_o,
    output mem_pkg::line_t      fetch_rdata_o,

    input  logic                data_req_i,
    input  logic [ADDR_W-1:0]   data_addr_i,
    input  logic                data_write_i,
    input  mem_pkg::line_t      data_wdata_i,
    output logic                data_ack_o,
    output mem_pkg::line_t      data_rdata_o,

    output logic [ADDR_W-1:0]   bmem_addr_o,
    output logic                bmem_read_o,
    output logic                bmem_write_o,
    output mem_pkg::beat_t      bmem_wdata_o,
    input  logic                bmem_ready_i,
    input  mem_pkg::beat_t      bmem_rdata_i,
    input  logic                bmem_rvalid_i
);

    logic               fetch_pending, fetch_write, fetch_done;
    logic [ADDR_W-1:0]  fetch_addr;
    mem_pkg::line_t     fetch_wdata;

    logic               data_pending, data_write, data_done;
    logic [ADDR_W-1:0]  data_addr;
    mem_pkg::line_t     data_wdata;

    mem_pkg::line_t     fill_rdata;     // returned line, to both ports

    logic               xfer_start, xfer_write, xfer_done;
    logic [ADDR_W-1:0]  xfer_addr;
    mem_pkg::line_t     xfer_wdata, xfer_rdata;

    req_port #(.ADDR_W(ADDR_W)) fetch_port_i (
        .clk(clk),                  .rst(rst),
        .req_i(fetch_req_i),        .addr_i(fetch_addr_i),
        .write_i(fetch_write_i),    .wdata_i(fetch_wdata_i),
        .ack_o(fetch_ack_o),        .rdata_o(fetch_rdata_o),
        .pending_o(fetch_pending),  .addr_o(fetch_addr),
        .write_o(fetch_write),      .wdata_o(fetch_wdata),
        .done_i(fetch_done),        .rdata_i(fill_rdata)
    );

    req_port #(.ADDR_W(ADDR_W)) data_port_i (
        .clk(clk),                  .rst(rst),
        .req_i(data_req_i),         .addr_i(data_addr_i),
        .write_i(data_write_i),     .wdata_i(data_wdata_i),
        .ack_o(data_ack_o),         .rdata_o(data_rdata_o),
        .pending_o(data_pending),   .addr_o(data_addr),
        .write_o(data_write),       .wdata_o(data_wdata),
        .done_i(data_done),         .rdata_i(fill_rdata)
    );

    fill_arbiter #(.ADDR_W(ADDR_W)) fill_arbiter_i (
        .clk(clk),                          .rst(rst),
        .fetch_pending_i(fetch_pending),    .fetch_addr_i(fetch_addr),
        .fetch_write_i(fetch_write),        .fetch_wdata_i(fetch_wdata),
        .data_pending_i(data_pending),      .data_addr_i(data_addr),
        .data_write_i(data_write),          .data_wdata_i(data_wdata),
        .fetch_done_o(fetch_done),          .data_done_o(data_done),
        .rdata_o(fill_rdata),
        .start_o(xfer_start),               .addr_o(xfer_addr),
        .write_o(xfer_write),               .wdata_o(xfer_wdata),
        .done_i(xfer_done),                 .rdata_i(xfer_rdata)
    );

    burst_adapter #(.ADDR_W(ADDR_W)) burst_adapter_i (
        .clk(clk),                      .rst(rst),
        .start_i(xfer_start),           .addr_i(xfer_addr),
        .write_i(xfer_write),           .wdata_i(xfer_wdata),
        .done_o(xfer_done),             .rdata_o(xfer_rdata),
        .bmem_addr_o(bmem_addr_o),      .bmem_read_o(bmem_read_o),
        .bmem_write_o(bmem_write_o),    .bmem_wdata_o(bmem_wdata_o),
        .bmem_ready_i(bmem_ready_i),    .bmem_rdata_i(bmem_rdata_i),
        .bmem_rvalid_i(bmem_rvalid_i)
    );

endmodule : line_fill_top

`default_nettype wire

// File: tb/bmem_model.sv
`default_nettype none

module bmem_model #(
    parameter int ADDR_W = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [ADDR_W-1:0]   addr_i,
    input  logic                read_i,
    input  logic                write_i,
    input  mem_pkg::beat_t      wdata_i,
    output logic                ready_o,
    output mem_pkg::beat_t      rdata_o,
    output logic                rvalid_o
);

    mem_pkg::line_t         store [logic [ADDR_W-1:0]];   // lines written so far
    logic [ADDR_W-1:0]      rd_addr;
    int                     rd_left;                      // beats still to return
    mem_pkg::beat_idx_t     rd_beat;
    mem_pkg::beat_idx_t     wr_beat;

    // unwritten lines read as a pattern of their address
    function automatic mem_pkg::line_t stored_line(input logic [ADDR_W-1:0] a);
        mem_pkg::line_t line;
        if (store.exists(a)) begin
            return store[a];
        end
        for (int k = 0; k < mem_pkg::BEATS; k++) begin
            line[k*mem_pkg::BEAT_BITS +: mem_pkg::BEAT_BITS] =
                {32'(a) ^ (32'hc0de_0000 | 32'(k)), 32'(a) + 32'(k * 8)};
        end
        return line;
    endfunction

    initial begin
        mem_pkg::line_t line;
        ready_o  = 1'b0;
        rvalid_o = 1'b0;
        rdata_o  = '0;
        rd_addr  = '0;
        rd_left  = 0;
        rd_beat  = '0;
        wr_beat  = '0;
        forever begin
            @(posedge clk);
            if (rst) begin
                rd_left = 0;
                rd_beat = '0;
                wr_beat = '0;
            end else begin
                if (rvalid_o) begin
                    rd_left--;              // beat taken at this edge
                    rd_beat++;
                end
                if (write_i && ready_o) begin
                    line = stored_line(addr_i);
                    line[wr_beat*mem_pkg::BEAT_BITS +: mem_pkg::BEAT_BITS] = wdata_i;
                    store[addr_i] = line;
                    wr_beat++;
                end
                if (read_i && ready_o) begin
                    rd_addr = addr_i;
                    rd_left = mem_pkg::BEATS;
                    rd_beat = '0;
                end
            end
            #1;
            ready_o = ($urandom % 4) != 0;  // stall about one cycle in four
            if (rd_left > 0 && ($urandom % 3) != 0) begin
                line     = stored_line(rd_addr);
                rvalid_o = 1'b1;
                rdata_o  = line[rd_beat*mem_pkg::BEAT_BITS +: mem_pkg::BEAT_BITS];
            end else begin
                rvalid_o = 1'b0;            // gap between beats
                rdata_o  = '0;
            end
        end
    end

endmodule : bmem_model

`default_nettype wire

// File: tb/tb_line_fill.sv
`default_nettype none

module tb_line_fill;

    localparam int ADDR_W         = 32;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RANDOM_TXNS    = 150;    // per client
    localparam int CONTEND_TXNS   = 20;
    localparam int TIE_ROUNDS     = 8;

    logic               clk;
    logic               rst;
    logic               fetch_req, fetch_write, fetch_ack;
    logic [ADDR_W-1:0]  fetch_addr;
    mem_pkg::line_t     fetch_wdata, fetch_rdata;
    logic               data_req, data_write, data_ack;
    logic [ADDR_W-1:0]  data_addr;
    mem_pkg::line_t     data_wdata, data_rdata;
    logic [ADDR_W-1:0]  bmem_addr;
    logic               bmem_read, bmem_write, bmem_ready, bmem_rvalid;
    mem_pkg::beat_t     bmem_wdata, bmem_rdata;

    mem_pkg::line_t     ref_mem [logic [ADDR_W-1:0]];  // expected memory contents
    arb_pkg::client_t   ack_order [$];                 // clients in order of ack rise
    logic               fetch_ack_prev, data_ack_prev, fetch_req_prev, data_req_prev;

    line_fill_top #(.ADDR_W(ADDR_W)) line_fill_top_i (
        .clk(clk),                      .rst(rst),
        .fetch_req_i(fetch_req),        .fetch_addr_i(fetch_addr),
        .fetch_write_i(fetch_write),    .fetch_wdata_i(fetch_wdata),
        .fetch_ack_o(fetch_ack),        .fetch_rdata_o(fetch_rdata),
        .data_req_i(data_req),          .data_addr_i(data_addr),
        .data_write_i(data_write),      .data_wdata_i(data_wdata),
        .data_ack_o(data_ack),          .data_rdata_o(data_rdata),
        .bmem_addr_o(bmem_addr),        .bmem_read_o(bmem_read),
        .bmem_write_o(bmem_write),      .bmem_wdata_o(bmem_wdata),
        .bmem_ready_i(bmem_ready),      .bmem_rdata_i(bmem_rdata),
        .bmem_rvalid_i(bmem_rvalid)
    );

    bmem_model #(.ADDR_W(ADDR_W)) bmem_model_i (
        .clk(clk),          .rst(rst),
        .addr_i(bmem_addr), .read_i(bmem_read),     .write_i(bmem_write),
        .wdata_i(bmem_wdata),
        .ready_o(bmem_ready), .rdata_o(bmem_rdata), .rvalid_o(bmem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_line(input string name, input mem_pkg::line_t expected,
                              input mem_pkg::line_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error in %s: expected %h, actual %h",
                                        name, expected, actual));
        end
    endtask

    task automatic check_ack(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error in %s: expected %b, actual %b",
                                        name, expected, actual));
        end
    endtask

    task automatic check_client(input string name, input arb_pkg::client_t expected,
                                input arb_pkg::client_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error in %s: expected %s, actual %s",
                                        name, expected.name(), actual.name()));
        end
    endtask

    function automatic logic [ADDR_W-1:0] line_base(input logic [ADDR_W-1:0] a);
        return {a[ADDR_W-1:mem_pkg::OFFSET_BITS], {mem_pkg::OFFSET_BITS{1'b0}}};
    endfunction

    // address pattern the memory holds before any write
    function automatic mem_pkg::line_t unwritten_line(input logic [ADDR_W-1:0] a);
        mem_pkg::line_t line;
        for (int k = 0; k < mem_pkg::BEATS; k++) begin
            line[k*mem_pkg::BEAT_BITS +: mem_pkg::BEAT_BITS] =
                {32'(a) ^ (32'hc0de_0000 | 32'(k)), 32'(a) + 32'(k * 8)};
        end
        return line;
    endfunction

    function automatic mem_pkg::line_t expected_line(input logic [ADDR_W-1:0] a);
        if (ref_mem.exists(line_base(a))) begin
            return ref_mem[line_base(a)];
        end
        return unwritten_line(line_base(a));
    endfunction

    function automatic mem_pkg::line_t random_line();
        mem_pkg::line_t line;
        for (int i = 0; i < mem_pkg::LINE_BITS / 32; i++) begin
            line[i*32 +: 32] = $urandom;
        end
        return line;
    endfunction

    // mostly a small set of lines so reads hit earlier writes
    function automatic logic [ADDR_W-1:0] random_addr();
        if ($urandom % 8 == 0) begin
            return ADDR_W'($urandom);
        end
        return ADDR_W'(32'h0004_0000) + ADDR_W'(($urandom % 16) << 5) + ADDR_W'($urandom % 32);
    endfunction

    function automatic logic ack_of(input arb_pkg::client_t who);
        return (who == arb_pkg::CLIENT_FETCH) ? fetch_ack : data_ack;
    endfunction

    function automatic mem_pkg::line_t rdata_of(input arb_pkg::client_t who);
        return (who == arb_pkg::CLIENT_FETCH) ? fetch_rdata : data_rdata;
    endfunction

    task automatic drive_request(input arb_pkg::client_t who, input logic req,
                                 input logic [ADDR_W-1:0] addr, input logic write,
                                 input mem_pkg::line_t wdata);
        if (who == arb_pkg::CLIENT_FETCH) begin
            fetch_req   = req;
            fetch_addr  = addr;
            fetch_write = write;
            fetch_wdata = wdata;
        end else begin
            data_req    = req;
            data_addr   = addr;
            data_write  = write;
            data_wdata  = wdata;
        end
    endtask

    task automatic wait_ack(input arb_pkg::client_t who, input logic level);
        int cycles;
        cycles = 0;
        while (ack_of(who) != level) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_failure($sformatf("timeout waiting for %s ack to go %b",
                                            who.name(), level));
            end
        end
    endtask

    // one four-phase transaction, entered and left just after a rising edge
    task automatic line_transaction(input arb_pkg::client_t who, input logic [ADDR_W-1:0] addr,
                                    input logic write, input mem_pkg::line_t wdata,
                                    input int hold, input string name);
        mem_pkg::line_t expected;
        check_ack(name, 1'b0, ack_of(who));
        drive_request(who, 1'b1, addr, write, wdata);
        wait_ack(who, 1'b1);
        expected = expected_line(addr);
        if (write) begin
            ref_mem[line_base(addr)] = wdata;   // write-back takes effect at ack
        end else begin
            check_line(name, expected, rdata_of(who));
        end
        repeat (hold) begin
            @(posedge clk);
            #1;
            check_ack(name, 1'b1, ack_of(who));
            if (!write) begin
                check_line(name, expected, rdata_of(who));
            end
        end
        drive_request(who, 1'b0, random_addr(), 1'b0, random_line());
        wait_ack(who, 1'b0);
    endtask

    task automatic run_client(input arb_pkg::client_t who, input int count,
                              input logic contend, input string name);
        logic write;
        for (int n = 0; n < count; n++) begin
            write = ($urandom % 2) == 1;
            if (!contend) begin
                repeat ($urandom % 4) begin
                    @(posedge clk);
                    #1;
                end
            end
            line_transaction(who, random_addr(), write, random_line(),
                             contend ? 0 : int'($urandom % 3), name);
        end
    endtask

    // one client alone, then both raise req in the same cycle on an idle arbiter
    task automatic tie_round(input arb_pkg::client_t solo, input string name);
        arb_pkg::client_t   winner;
        int                 first;
        winner = (solo == arb_pkg::CLIENT_FETCH) ? arb_pkg::CLIENT_DATA
                                                 : arb_pkg::CLIENT_FETCH;
        line_transaction(solo, random_addr(), 1'b0, '0, 0, name);
        first = ack_order.size();
        fork
            line_transaction(arb_pkg::CLIENT_FETCH, random_addr(), 1'b0, '0, 0, name);
            line_transaction(arb_pkg::CLIENT_DATA, random_addr(), 1'b0, '0, 0, name);
        join
        if (ack_order.size() - first != 2) begin
            stop_with_failure("wrong number of ack rises after a tie");
        end
        check_client(name, winner, ack_order[first]);
    endtask

    // handshake and bmem protocol watch, one sample per cycle
    always @(negedge clk) begin
        if (rst) begin
            fetch_ack_prev = 1'b0;
            data_ack_prev  = 1'b0;
            fetch_req_prev = 1'b0;
            data_req_prev  = 1'b0;
        end else begin
            if (bmem_read && bmem_write) begin
                stop_with_failure("bmem read and write were high in the same cycle");
            end
            if ((bmem_read || bmem_write) && bmem_addr[mem_pkg::OFFSET_BITS-1:0] != '0) begin
                stop_with_failure("bmem address was not line aligned");
            end
            if (fetch_ack && !fetch_ack_prev) begin
                if (!fetch_req_prev) begin
                    stop_with_failure("fetch ack rose without a request");
                end
                ack_order.push_back(arb_pkg::CLIENT_FETCH);
            end
            if (data_ack && !data_ack_prev) begin
                if (!data_req_prev) begin
                    stop_with_failure("data ack rose without a request");
                end
                ack_order.push_back(arb_pkg::CLIENT_DATA);
            end
            if (!fetch_ack && fetch_ack_prev && fetch_req_prev) begin
                stop_with_failure("fetch ack fell while req was still high");
            end
            if (!data_ack && data_ack_prev && data_req_prev) begin
                stop_with_failure("data ack fell while req was still high");
            end
            fetch_ack_prev = fetch_ack;
            data_ack_prev  = data_ack;
            fetch_req_prev = fetch_req;
            data_req_prev  = data_req;
        end
    end

    initial begin
        logic [ADDR_W-1:0]  addr;
        mem_pkg::line_t     wdata;
        int                 first;
        void'($urandom(67));
        rst = 1'b1;
        drive_request(arb_pkg::CLIENT_FETCH, 1'b0, '0, 1'b0, '0);
        drive_request(arb_pkg::CLIENT_DATA, 1'b0, '0, 1'b0, '0);
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_ack("reset fetch ack", 1'b0, fetch_ack);
        check_ack("reset data ack", 1'b0, data_ack);
        check_ack("reset bmem read", 1'b0, bmem_read);
        check_ack("reset bmem write", 1'b0, bmem_write);

        addr = random_addr();
        line_transaction(arb_pkg::CLIENT_FETCH, addr, 1'b0, '0, 2, "fetch read");

        addr  = random_addr();
        wdata = random_line();
        line_transaction(arb_pkg::CLIENT_DATA, addr, 1'b1, wdata, 0, "data write-back");
        line_transaction(arb_pkg::CLIENT_FETCH, line_base(addr) + ADDR_W'(7), 1'b0, '0, 1,
                         "fetch read after write-back");
        check_line("fetch readback", wdata, fetch_rdata);
        line_transaction(arb_pkg::CLIENT_DATA, addr, 1'b0, '0, 0, "data read after write-back");
        check_line("data readback", wdata, data_rdata);

        fork
            run_client(arb_pkg::CLIENT_FETCH, RANDOM_TXNS, 1'b0, "random traffic");
            run_client(arb_pkg::CLIENT_DATA, RANDOM_TXNS, 1'b0, "random traffic");
        join

        first = ack_order.size();
        fork
            run_client(arb_pkg::CLIENT_FETCH, CONTEND_TXNS, 1'b1, "contention");
            run_client(arb_pkg::CLIENT_DATA, CONTEND_TXNS, 1'b1, "contention");
        join
        if (ack_order.size() - first != 2 * CONTEND_TXNS) begin
            stop_with_failure("wrong number of ack rises under contention");
        end
        for (int i = first + 1; i < ack_order.size(); i++) begin
            check_client("alternating grants",
                         (ack_order[i-1] == arb_pkg::CLIENT_FETCH) ? arb_pkg::CLIENT_DATA
                                                                   : arb_pkg::CLIENT_FETCH,
                         ack_order[i]);
        end

        for (int r = 0; r < TIE_ROUNDS; r++) begin
            tie_round((r % 2 == 0) ? arb_pkg::CLIENT_FETCH : arb_pkg::CLIENT_DATA,
                      "tie break");
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule : tb_line_fill

`default_nettype wire

// File: sources.f
hw/mem_pkg.sv
hw/arb_pkg.sv
hw/req_port.sv
hw/fill_arbiter.sv
hw/burst_adapter.sv
hw/line_fill_top.sv
tb/bmem_model.sv
tb/tb_line_fill.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_line_fill
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
